//--- src.f
verilog/pat_isa_pkg.sv
verilog/pat_cfg_pkg.sv
verilog/pat_decode_if.sv
verilog/pat_alu.sv
verilog/pat_decoder.sv
verilog/pat_execute.sv
verilog/pat_program_counter.sv
verilog/pat_core.sv
verif/pat_core_checker.sv
verif/pat_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pat_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module pat_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vpat_core_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

//--- verif/pat_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pat_core_tb
	import pat_isa_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int MAX_TESTS = 32;
	localparam int PROG_LEN = 16;
	localparam int MAX_JUMPS = 4;
	localparam int TEST_CYCLES = 200; // watchdog budget per test
	localparam int DRAIN_PC = 40; // beyond every program and branch target

	logic clk = 1'b0;
	logic reset;
	logic [22:0] i_instruction;
	logic [9:0] o_pc;
	logic o_jump;
	logic [7:0] o_out;
	logic o_out_valid;

	logic [22:0] prog_mem [1024];
	string t_name [MAX_TESTS];
	logic [22:0] t_prog [MAX_TESTS][PROG_LEN];
	logic [7:0] t_exp [MAX_TESTS][PROG_LEN];
	int t_nexp [MAX_TESTS];
	logic [9:0] t_jmp [MAX_TESTS][MAX_JUMPS]; // taken branch targets
	int t_njmp [MAX_TESTS];
	int n_tests = 0;
	int n_words = 0;
	bit table_ready = 1'b0;
	int seed = 32'h94f4d274;

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		i_instruction <= prog_mem[o_pc]; // word for the address just shown

	pat_core pat_core_inst (
		.clk(clk),
		.reset(reset),
		.i_instruction(i_instruction),
		.o_pc(o_pc),
		.o_jump(o_jump),
		.o_out(o_out),
		.o_out_valid(o_out_valid)
	);

	pat_core_checker checker_inst (
		.clk(clk),
		.reset(reset),
		.i_out(o_out),
		.i_out_valid(o_out_valid),
		.i_pc(o_pc),
		.i_jump(o_jump)
	);

	// ==================================================
	// instruction encoding and reference model
	// ==================================================
	function automatic logic [22:0] enc8(cond_e c, op_i8_e op, int rn, logic [7:0] imm);
		return {3'(rn), 5'b0, c, 1'b0, op, imm}; // reserved bits zero
	endfunction

	function automatic logic [22:0] enc3(cond_e c, op_i3_e op, int rn, int s);
		return enc8(c, OP8_PREFIX_I3, rn, {op, 1'b0, 3'(s)});
	endfunction

	function automatic logic [22:0] enc0(op_i0_e op, int rn);
		return enc8(COND_AL, OP8_PREFIX_I3, rn, {OP3_PREFIX_I0, op});
	endfunction

	function automatic logic [22:0] ldi(int rn, logic [7:0] v);
		return enc8(COND_AL, OP8_LDI, rn, v);
	endfunction

	function automatic logic [22:0] out_w(cond_e c, int rn);
		return enc3(c, OP3_OUT, rn, 0);
	endfunction

	// nop with address bits in the ignored fields
	function automatic logic [22:0] nop_fill(int a);
		logic [9:0] adr;
		logic [22:0] w;
		adr = 10'(a);
		w = INSTR_NOP;
		w[22:20] = adr[2:0];
		w[19:15] = adr[7:3];
		w[14:13] = adr[9:8];
		return w;
	endfunction

	function automatic logic [7:0] ref_arith(op_i8_e op, logic [7:0] a, logic [7:0] b);
		logic [8:0] full;
		case (op)
			OP8_ANDI, OP8_ANDR: return a & b;
			OP8_ADDI, OP8_ADDR: full = {1'b0, a} + {1'b0, b};
			default: full = {1'b0, a} + 9'(256 - int'(b)); // sub as two's complement add
		endcase
		return full[7:0]; // modulo 256
	endfunction

	function automatic logic [7:0] ref_shift(op_i3_e op, logic [7:0] a, logic [7:0] amt);
		logic [7:0] y;
		int s;
		int j;
		s = int'(amt[2:0]); // only the low three bits count
		for (int i = 0; i < 8; i++)
		begin
			if (op inside {OP3_SHLZI, OP3_SHLZR, OP3_SHLOI, OP3_SHLOR})
				j = i - s; // bit i comes from further down
			else
				j = i + s;
			if (j >= 0 && j <= 7)
				y[i] = a[j];
			else if (op inside {OP3_SHLOI, OP3_SHLOR})
				y[i] = 1'b1; // one fill
			else if (op inside {OP3_ASRI, OP3_ASRR})
				y[i] = a[7]; // sign fill
			else
				y[i] = 1'b0;
		end
		return y;
	endfunction

	// ==================================================
	// test table
	// ==================================================
	task automatic new_entry(input string name);
		n_tests++;
		t_name[n_tests-1] = name;
		t_nexp[n_tests-1] = 0;
		t_njmp[n_tests-1] = 0;
		n_words = 0;
		for (int i = 0; i < PROG_LEN; i++)
			t_prog[n_tests-1][i] = INSTR_NOP;
	endtask

	task automatic put(input logic [22:0] w);
		t_prog[n_tests-1][n_words] = w;
		n_words++;
	endtask

	task automatic expect_out(input logic [7:0] v);
		t_exp[n_tests-1][t_nexp[n_tests-1]] = v;
		t_nexp[n_tests-1]++;
	endtask

	task automatic expect_jump(input int target);
		t_jmp[n_tests-1][t_njmp[n_tests-1]] = 10'(target);
		t_njmp[n_tests-1]++;
	endtask

	task automatic build_table();
		op_i3_e op3;
		op_i8_e op8;
		logic [7:0] v;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] imm;
		int idx;
		int amt;
		new_entry("alu_imm");
		put(ldi(1, 8'hf0));
		put(enc8(COND_AL, OP8_ORI, 1, 8'h3c)); // overlapping bits, or differs from add
		put(out_w(COND_AL, 1));
		put(enc8(COND_AL, OP8_ANDI, 1, 8'h5a));
		put(out_w(COND_AL, 1));
		put(enc8(COND_AL, OP8_ADDI, 1, 8'hf0));
		put(out_w(COND_AL, 1)); // 58+f0 wraps
		put(enc8(COND_AL, OP8_SUBI, 1, 8'h50));
		put(out_w(COND_AL, 1)); // 48-50 wraps
		expect_out(8'hfc);
		expect_out(8'h58);
		expect_out(8'h48);
		expect_out(8'hf8);
		new_entry("alu_reg");
		put(ldi(2, 8'h55));
		put(ldi(3, 8'ha6));
		put(ldi(4, 8'h3c));
		put(enc8(COND_AL, OP8_ORR, 2, 8'd3));
		put(out_w(COND_AL, 2));
		put(enc8(COND_AL, OP8_ANDR, 2, 8'd4));
		put(out_w(COND_AL, 2));
		put(enc8(COND_AL, OP8_ADDR, 2, 8'd3));
		put(out_w(COND_AL, 2));
		put(enc8(COND_AL, OP8_SUBR, 3, 8'd2)); // a6-da wraps
		put(out_w(COND_AL, 3));
		put(enc8(COND_AL, OP8_SUBR, 2, 8'd3));
		put(out_w(COND_AL, 2));
		expect_out(8'hf7);
		expect_out(8'h34);
		expect_out(8'hda);
		expect_out(8'hcc);
		expect_out(8'h0e);
		// 4 shifts x imm/reg x two halves of the amount range
		for (int kind = 0; kind < 4; kind++)
			for (int form = 0; form < 2; form++)
				for (int half = 0; half < 2; half++)
				begin
					op3 = op_i3_e'(kind * 2 + form);
					v = half ? 8'hb4 : 8'h96; // msb set to show sign fill
					new_entry($sformatf("shift_%s_%0d", op3.name(), half));
					for (int k = 0; k < 4; k++)
						put(ldi(k, v));
					for (int k = 0; form && k < 4; k++)
						put(ldi(4 + k, {5'b10101, 3'(half * 4 + k)})); // upper bits ignored
					for (int k = 0; k < 4; k++)
					begin
						amt = half * 4 + k;
						put(enc3(COND_AL, op3, k, form ? 4 + k : amt));
						put(out_w(COND_AL, k));
						expect_out(ref_shift(op3, v, 8'(amt)));
					end
				end
		new_entry("cond_out");
		put(ldi(1, 8'h00));
		put(enc0(OP0_TEST, 1)); // z set
		put(out_w(COND_Z, 1));
		put(out_w(COND_NZ, 1));
		put(out_w(COND_N, 1));
		put(enc0(OP0_NOT, 1));
		put(enc0(OP0_TEST, 1)); // n set
		put(out_w(COND_Z, 1));
		put(out_w(COND_NZ, 1));
		put(out_w(COND_N, 1));
		put(ldi(2, 8'h7f));
		put(enc0(OP0_TEST, 2)); // both clear
		put(out_w(COND_N, 2));
		put(out_w(COND_NZ, 2));
		put(out_w(COND_Z, 2));
		expect_out(8'h00);
		expect_out(8'hff);
		expect_out(8'hff);
		expect_out(8'h7f);
		new_entry("bf_forward");
		put(ldi(1, 8'h11));
		put(enc8(COND_AL, OP8_BF, 0, 8'd4)); // to word 5
		put(out_w(COND_AL, 1));
		put(out_w(COND_AL, 1));
		put(out_w(COND_AL, 1));
		put(ldi(1, 8'h22));
		put(out_w(COND_AL, 1));
		expect_out(8'h22);
		expect_jump(5);
		new_entry("bf_fall_through");
		put(ldi(1, 8'h00));
		put(enc0(OP0_TEST, 1));
		put(enc8(COND_NZ, OP8_BF, 0, 8'd5)); // not taken
		put(ldi(1, 8'h33));
		put(out_w(COND_AL, 1));
		put(enc8(COND_Z, OP8_BF, 0, 8'd3)); // taken, to word 8
		put(out_w(COND_AL, 1));
		put(out_w(COND_AL, 1));
		put(ldi(1, 8'h44));
		put(out_w(COND_AL, 1));
		expect_out(8'h33);
		expect_out(8'h44);
		expect_jump(8);
		new_entry("bf_loop");
		put(ldi(1, 8'd3));
		put(out_w(COND_AL, 1));
		put(enc8(COND_AL, OP8_SUBI, 1, 8'd1));
		put(enc0(OP0_TEST, 1));
		put(enc8(COND_NZ, OP8_BF, 0, 8'hfd)); // back to word 1
		put(out_w(COND_AL, 1)); // only on the exit pass
		put(out_w(COND_AL, 1));
		expect_out(8'd3);
		expect_out(8'd2);
		expect_out(8'd1);
		expect_out(8'd0);
		expect_out(8'd0);
		expect_jump(1);
		expect_jump(1);
		for (int r = 0; r < 2; r++)
		begin
			new_entry($sformatf("random_%0d", r));
			a = 8'($random(seed));
			b = 8'($random(seed));
			put(ldi(1, a));
			put(ldi(2, b));
			for (int k = 0; k < 7; k++)
			begin
				idx = int'($unsigned($random(seed)) % 6);
				op8 = op_i8_e'((idx < 4) ? 4 + idx : idx - 2); // add, sub or and forms
				imm = 8'($random(seed));
				a = ref_arith(op8, a, op8[0] ? b : imm);
				put(enc8(COND_AL, op8, 1, op8[0] ? 8'd2 : imm));
				put(out_w(COND_AL, 1));
				expect_out(a);
			end
		end
		table_ready = 1'b1;
	endtask

	// ==================================================
	// run one entry
	// ==================================================
	task automatic run_test(input int t);
		int cyc;
		@(posedge clk);
		reset <= 1'b1;
		for (int adr = 0; adr < 1024; adr++)
			prog_mem[adr] = (adr < PROG_LEN) ? t_prog[t][adr] : nop_fill(adr);
		checker_inst.begin_test(t_name[t]);
		for (int e = 0; e < t_nexp[t]; e++)
			checker_inst.add_expected(t_exp[t][e]);
		for (int e = 0; e < t_njmp[t]; e++)
			checker_inst.add_jump(t_jmp[t][e]);
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		cyc = 0;
		// all outputs seen and pc run past the program
		while ((checker_inst.pending() != 0 || o_pc < DRAIN_PC) && cyc < TEST_CYCLES / 2)
		begin
			@(posedge clk);
			cyc++;
		end
		if (cyc >= TEST_CYCLES / 2)
			checker_inst.note_failure("timed out waiting for the program to finish");
		checker_inst.end_test();
	endtask

	initial
	begin
		reset = 1'b1;
		i_instruction = INSTR_NOP;
		for (int adr = 0; adr < 1024; adr++)
			prog_mem[adr] = nop_fill(adr);
		build_table();
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		if (checker_inst.error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$display("tests %0d, passed %0d, failed %0d, errors %0d", n_tests, checker_inst.passed,
			checker_inst.failed, checker_inst.error_count);
		$finish;
	end

	// watchdog
	initial
	begin
		wait (table_ready);
		#(n_tests * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all tests completed");
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/pat_core_checker.sv
`timescale 1ns/10ps
`default_nettype none

module pat_core_checker
(
	input logic clk,
	input logic reset,
	input logic [7:0] i_out,
	input logic i_out_valid,
	input logic [9:0] i_pc,
	input logic i_jump
);

	string test_name = "";
	logic [7:0] exp_q [$]; // outputs still to come, in order
	logic [9:0] jmp_q [$]; // branch targets still to come, in order
	logic [7:0] expected;
	logic [9:0] exp_target;
	bit active = 1'b0;
	int test_errors = 0;
	int n_outputs = 0;
	int error_count = 0; // over the whole run
	int passed = 0;
	int failed = 0;

	task automatic begin_test(input string name);
		test_name = name;
		exp_q.delete();
		jmp_q.delete();
		test_errors = 0;
		n_outputs = 0;
		active = 1'b1;
	endtask

	task automatic add_expected(input logic [7:0] value);
		exp_q.push_back(value);
	endtask

	task automatic add_jump(input logic [9:0] target);
		jmp_q.push_back(target);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic note_failure(input string what);
		$display("%s: %s", test_name, what);
		test_errors++;
		error_count++;
	endtask

	task automatic end_test();
		if (exp_q.size() != 0)
			note_failure($sformatf("%0d expected outputs never appeared", exp_q.size()));
		if (jmp_q.size() != 0)
			note_failure($sformatf("%0d expected jumps never happened", jmp_q.size()));
		if (test_errors == 0)
			passed++;
		else
			failed++;
		$display("test %s: %s, %0d outputs", test_name, (test_errors == 0) ? "pass" : "FAIL",
			n_outputs);
		active = 1'b0;
	endtask

	// ==================================================
	// output monitor, sampled mid-cycle
	// ==================================================
	always @(negedge clk)
	begin
		if (!reset && i_out_valid)
		begin
			if (!active)
			begin
				$display("output %02h appeared outside any test", i_out);
				error_count++;
			end
			else if (exp_q.size() == 0)
				note_failure($sformatf("extra output %02h after the last expected one", i_out));
			else
			begin
				expected = exp_q.pop_front();
				n_outputs++;
				if (expected !== i_out)
				begin
					$display("[ERROR] %s: expected %02h, actual %02h", test_name, expected, i_out);
					test_errors++;
					error_count++;
				end
			end
		end
	end

	// jump pulse is one cycle wide and the pc already shows the target
	always @(negedge clk)
	begin
		if (!reset && i_jump)
		begin
			if (!active)
			begin
				$display("jump to %0d happened outside any test", i_pc);
				error_count++;
			end
			else if (jmp_q.size() == 0)
				note_failure($sformatf("unexpected jump to %0d", i_pc));
			else
			begin
				exp_target = jmp_q.pop_front();
				if (exp_target !== i_pc)
				begin
					$display("[ERROR] %s: jump target expected %0d, actual %0d", test_name,
						exp_target, i_pc);
					test_errors++;
					error_count++;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/pat_core.sv
`timescale 1ns/10ps
`default_nettype none

module pat_core
	import pat_cfg_pkg::*;
#(
	parameter int I_ADR_WIDTH = I_ADR_WIDTH_DEF,
	parameter int D_WIDTH = D_WIDTH_DEF
)
(
	input logic clk,
	input logic reset,
	input logic [I_WIDTH_DEF-1:0] i_instruction, // word for last cycle's o_pc
	output logic [I_ADR_WIDTH-1:0] o_pc,
	output logic o_jump,
	output logic [D_WIDTH-1:0] o_out,
	output logic o_out_valid
);

	// ==================================================
	// stage links
	// ==================================================
	logic branch; // execute -> pc
	logic [D_WIDTH-1:0] offset;
	logic flush; // pc -> decode

	pat_decode_if #(.D_WIDTH(D_WIDTH)) dec_if ();

	// stage 1
	pat_decoder #(.D_WIDTH(D_WIDTH)) decoder_inst (
		.clk(clk),
		.reset(reset),
		.i_instruction(i_instruction),
		.i_flush(flush),
		.o_dec(dec_if.source)
	);

	// stage 2
	pat_execute #(.D_WIDTH(D_WIDTH)) execute_inst (
		.clk(clk),
		.reset(reset),
		.i_dec(dec_if.sink),
		.o_branch(branch),
		.o_offset(offset),
		.o_out(o_out),
		.o_out_valid(o_out_valid)
	);

	pat_program_counter #(.I_ADR_WIDTH(I_ADR_WIDTH), .D_WIDTH(D_WIDTH)) pc_inst (
		.clk(clk),
		.reset(reset),
		.i_branch(branch),
		.i_offset(offset),
		.o_pc(o_pc),
		.o_jump(o_jump),
		.o_flush(flush)
	);

endmodule

`default_nettype wire

//--- verilog/pat_program_counter.sv
`timescale 1ns/10ps
`default_nettype none

module pat_program_counter
	import pat_cfg_pkg::*;
#(
	parameter int I_ADR_WIDTH = I_ADR_WIDTH_DEF,
	parameter int D_WIDTH = D_WIDTH_DEF
)
(
	input logic clk,
	input logic reset,
	input logic i_branch,
	input logic [D_WIDTH-1:0] i_offset, // signed
	output logic [I_ADR_WIDTH-1:0] o_pc,
	output logic o_jump,
	output logic o_flush
);

	localparam int SQ_W = $clog2(SQUASH_COUNT + 1);
	localparam logic [I_ADR_WIDTH-1:0] PC_LAG = I_ADR_WIDTH'(BRANCH_PC_LAG);

	logic [I_ADR_WIDTH-1:0] pc_inc;
	logic [I_ADR_WIDTH-1:0] offset_ext;
	logic [I_ADR_WIDTH-1:0] target;
	logic [SQ_W-1:0] squash_cnt; // remaining squash slots after the first

	assign pc_inc = o_pc + I_ADR_WIDTH'(1);
	assign offset_ext = {{(I_ADR_WIDTH-D_WIDTH){i_offset[D_WIDTH-1]}}, i_offset};
	// pc_inc is BRANCH_PC_LAG past the bf, so this lands on bf + offset
	assign target = pc_inc - PC_LAG + offset_ext;

	// first squash slot is the commit edge itself
	assign o_flush = i_branch || (squash_cnt != '0);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_pc <= '0;
			o_jump <= 1'b0;
			squash_cnt <= '0;
		end
		else
		begin
			o_pc <= i_branch ? target : pc_inc;
			o_jump <= i_branch; // one cycle after the load
			if (i_branch)
				squash_cnt <= SQ_W'(SQUASH_COUNT - 1);
			else if (squash_cnt != '0)
				squash_cnt <= squash_cnt - SQ_W'(1);
		end
	end

	// squash window keeps any second branch out of the pipe
	a_no_branch_in_jump: assert property (@(posedge clk) disable iff (reset)
		o_jump |-> !i_branch);

endmodule

`default_nettype wire

//--- verilog/pat_execute.sv
`timescale 1ns/10ps
`default_nettype none

module pat_execute
	import pat_isa_pkg::*, pat_cfg_pkg::*;
#(
	parameter int D_WIDTH = D_WIDTH_DEF
)
(
	input logic clk,
	input logic reset,
	pat_decode_if.sink i_dec,
	output logic o_branch, // taken bf, combinational this cycle
	output logic [D_WIDTH-1:0] o_offset, // raw 8-bit offset
	output logic [D_WIDTH-1:0] o_out,
	output logic o_out_valid
);

	localparam int NUM_REGS = 1 << REG_ADR_WIDTH;

	logic [D_WIDTH-1:0] regs [NUM_REGS]; // register file
	logic flag_z;
	logic flag_n;
	logic [D_WIDTH-1:0] rn_val;
	logic [D_WIDTH-1:0] opnd_b;
	logic [D_WIDTH-1:0] alu_y;
	logic cond_ok;
	commit_e eff_commit; // commit after predication

	// ==================================================
	// operands and alu
	// ==================================================
	assign rn_val = regs[i_dec.rd]; // read at execute time so no hazards
	assign opnd_b = i_dec.use_reg ? regs[i_dec.src_reg] : i_dec.imm;

	pat_alu #(.D_WIDTH(D_WIDTH)) alu_inst (
		.i_a(rn_val),
		.i_b(opnd_b),
		.i_op(i_dec.alu_op),
		.o_y(alu_y)
	);

	// predication on the stored flags
	always_comb
	begin
		case (i_dec.cond)
			COND_Z: cond_ok = flag_z;
			COND_NZ: cond_ok = !flag_z; // zero clear
			COND_N: cond_ok = flag_n;
			default: cond_ok = 1'b1; // always
		endcase
	end

	assign eff_commit = cond_ok ? i_dec.commit : CM_NONE;

	assign o_branch = (eff_commit == CM_BRANCH);
	assign o_offset = alu_y; // imm passed through b

	// ==================================================
	// commit
	// ==================================================
	always_ff @(posedge clk)
	begin
		o_out_valid <= 1'b0; // single-cycle strobe
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
			flag_z <= 1'b0;
			flag_n <= 1'b0;
		end
		else
		begin
			case (eff_commit)
				CM_WRITE: regs[i_dec.rd] <= alu_y;
				CM_TEST:
				begin
					flag_z <= (rn_val == '0);
					flag_n <= rn_val[D_WIDTH-1];
				end
				CM_OUT:
				begin
					o_out <= rn_val;
					o_out_valid <= 1'b1;
				end
				default: ; // branch handled by the pc, none does nothing
			endcase
		end
	end

	// the squashed slot after a branch is a nop from the decoder
	a_branch_single: assert property (@(posedge clk) disable iff (reset)
		o_branch |=> !o_branch);

endmodule

`default_nettype wire

//--- verilog/pat_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module pat_decoder
	import pat_isa_pkg::*, pat_cfg_pkg::*;
#(
	parameter int D_WIDTH = D_WIDTH_DEF
)
(
	input logic clk,
	input logic reset,
	input logic [I_WIDTH_DEF-1:0] i_instruction,
	input logic i_flush, // squash window from the pc
	pat_decode_if.source o_dec
);

	// ==================================================
	// field split
	// ==================================================
	logic [REG_ADR_WIDTH-1:0] rn;
	logic [REG_ADR_WIDTH-1:0] src;
	cond_e cond;
	op_i8_e op8;
	op_i3_e op3;
	op_i0_e op0;
	logic [IMM_MSB:0] imm8;
	logic [D_WIDTH-1:0] imm_sel; // imm handed to execute
	alu_op_e alu_op;
	commit_e commit;
	logic use_reg;

	assign rn = i_instruction[RN_MSB:RN_LSB];
	assign src = i_instruction[IMM3_MSB:IMM3_LSB];
	assign cond = cond_e'(i_instruction[COND_MSB:COND_LSB]);
	assign op8 = op_i8_e'(i_instruction[OP8_MSB:OP8_LSB]);
	assign op3 = op_i3_e'(i_instruction[OP3_MSB:OP3_LSB]);
	assign op0 = op_i0_e'(i_instruction[OP0_MSB:OP0_LSB]);
	assign imm8 = i_instruction[IMM_MSB:IMM_LSB];

	// ==================================================
	// classify
	// ==================================================
	always_comb
	begin
		alu_op = ALU_PASS_B;
		commit = CM_NONE; // unknown opcodes fall out as no-ops
		use_reg = 1'b0;
		imm_sel = D_WIDTH'(imm8);
		case (op8)
			OP8_ORI, OP8_ORR: begin alu_op = ALU_OR; commit = CM_WRITE; use_reg = op8[0]; end
			OP8_ANDI, OP8_ANDR: begin alu_op = ALU_AND; commit = CM_WRITE; use_reg = op8[0]; end
			OP8_ADDI, OP8_ADDR: begin alu_op = ALU_ADD; commit = CM_WRITE; use_reg = op8[0]; end
			OP8_SUBI, OP8_SUBR: begin alu_op = ALU_SUB; commit = CM_WRITE; use_reg = op8[0]; end
			OP8_LDI: commit = CM_WRITE; // pass-b of imm8
			OP8_BF: commit = CM_BRANCH; // offset rides through as pass-b
			OP8_PREFIX_I3:
			begin
				imm_sel = D_WIDTH'(src); // short imm, zero extended
				use_reg = op3[0]; // odd i3 opcodes take the register
				case (op3)
					OP3_SHLZI, OP3_SHLZR: begin alu_op = ALU_SHLZ; commit = CM_WRITE; end
					OP3_SHLOI, OP3_SHLOR: begin alu_op = ALU_SHLO; commit = CM_WRITE; end
					OP3_SHRZI, OP3_SHRZR: begin alu_op = ALU_SHRZ; commit = CM_WRITE; end
					OP3_ASRI, OP3_ASRR: begin alu_op = ALU_ASR; commit = CM_WRITE; end
					OP3_OUT: commit = CM_OUT;
					OP3_PREFIX_I0:
					begin
						case (op0)
							OP0_NOT: begin alu_op = ALU_NOT; commit = CM_WRITE; end
							OP0_TEST: commit = CM_TEST;
							default: commit = CM_NONE; // nop and holes
						endcase
					end
					default: commit = CM_NONE;
				endcase
			end
			default: commit = CM_NONE;
		endcase
	end

	// ==================================================
	// decode register
	// ==================================================
	always_ff @(posedge clk)
	begin
		o_dec.rd <= rn; // payload carries no reset
		o_dec.src_reg <= src;
		o_dec.use_reg <= use_reg;
		o_dec.imm <= imm_sel;
		if (reset || i_flush)
		begin
			o_dec.alu_op <= ALU_PASS_B; // slot becomes nop
			o_dec.commit <= CM_NONE;
			o_dec.cond <= COND_AL;
		end
		else
		begin
			o_dec.alu_op <= alu_op;
			o_dec.commit <= commit;
			o_dec.cond <= cond;
		end
	end

	// execute takes the branch offset straight off the alu
	a_branch_pass_b: assert property (@(posedge clk) disable iff (reset)
		(o_dec.commit == CM_BRANCH) |-> (o_dec.alu_op == ALU_PASS_B));

endmodule

`default_nettype wire

//--- verilog/pat_alu.sv
`timescale 1ns/10ps
`default_nettype none

module pat_alu
	import pat_isa_pkg::*, pat_cfg_pkg::*;
#(
	parameter int D_WIDTH = D_WIDTH_DEF
)
(
	input logic [D_WIDTH-1:0] i_a, // Rn
	input logic [D_WIDTH-1:0] i_b, // imm or second register
	input alu_op_e i_op,
	output logic [D_WIDTH-1:0] o_y
);

	localparam int SH_W = $clog2(D_WIDTH); // shift amount bits

	logic [SH_W-1:0] sh_amt;
	logic sub_sel;
	logic [D_WIDTH-1:0] b_addsub;
	logic [D_WIDTH-1:0] sum;

	assign sh_amt = i_b[SH_W-1:0]; // upper bits of b ignored

	// ==================================================
	// shared add/sub
	// ==================================================
	// a - b as a + ~b + 1
	assign sub_sel = (i_op == ALU_SUB);
	assign b_addsub = sub_sel ? ~i_b : i_b;
	assign sum = i_a + b_addsub + D_WIDTH'(sub_sel); // wraps modulo 2^D_WIDTH

	// ==================================================
	// result select
	// ==================================================
	always_comb
	begin
		case (i_op)
			ALU_OR: o_y = i_a | i_b;
			ALU_AND: o_y = i_a & i_b;
			ALU_ADD, ALU_SUB: o_y = sum;
			ALU_NOT: o_y = ~i_a;
			ALU_SHLZ: o_y = i_a << sh_amt;
			// ones shifted in from the right
			ALU_SHLO: o_y = ~((~i_a) << sh_amt);
			ALU_SHRZ: o_y = i_a >> sh_amt;
			ALU_ASR: o_y = $signed(i_a) >>> sh_amt; // msb copied down
			default: o_y = i_b; // pass-b for ldi and bf
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/pat_decode_if.sv
`timescale 1ns/10ps
`default_nettype none

// one decoded slot, registered in decode and consumed by execute
interface pat_decode_if
	import pat_isa_pkg::*, pat_cfg_pkg::*;
#(
	parameter int D_WIDTH = D_WIDTH_DEF
)
();

	logic [REG_ADR_WIDTH-1:0] rd; // Rn field
	logic [REG_ADR_WIDTH-1:0] src_reg; // second register for the R forms
	logic use_reg; // b comes from src_reg instead of imm
	logic [D_WIDTH-1:0] imm; // imm8, or zero-extended imm3
	alu_op_e alu_op;
	commit_e commit; // none for squashed or reset slots
	cond_e cond;

	modport source (
		output rd, src_reg, use_reg, imm, alu_op, commit, cond
	);

	modport sink (
		input rd, src_reg, use_reg, imm, alu_op, commit, cond
	);

endinterface

`default_nettype wire

//--- verilog/pat_cfg_pkg.sv
`default_nettype none

package pat_cfg_pkg;

	// ==================================================
	// default machine sizes
	// ==================================================
	localparam int I_ADR_WIDTH_DEF = 10; // 1k instruction words
	localparam int I_WIDTH_DEF = 23; // instruction word
	localparam int D_WIDTH_DEF = 8; // data path
	localparam int REG_ADR_WIDTH = 3; // 8 registers

	// ==================================================
	// pipeline properties
	// ==================================================
	// addresses the pc has advanced past a branch by its commit edge
	localparam int BRANCH_PC_LAG = 3;
	// wrong-path slots turned into nop after a taken branch
	localparam int SQUASH_COUNT = 2;

endpackage

`default_nettype wire

//--- verilog/pat_isa_pkg.sv
`default_nettype none

package pat_isa_pkg;

	// ==================================================
	// instruction word layout
	// ==================================================
	localparam int RN_MSB = 22; // source and destination register
	localparam int RN_LSB = 20;
	localparam int COND_MSB = 14; // bits 19..15 and 12 are reserved
	localparam int COND_LSB = 13;
	localparam int OP8_MSB = 11;
	localparam int OP8_LSB = 8;
	localparam int IMM_MSB = 7;
	localparam int IMM_LSB = 0;
	localparam int OP3_MSB = 7; // i3 opcode sits in the immediate
	localparam int OP3_LSB = 4;
	localparam int OP0_MSB = 3; // i0 opcode under the i3 prefix
	localparam int OP0_LSB = 0;
	localparam int IMM3_MSB = 2; // short immediate or source register
	localparam int IMM3_LSB = 0;

	// ==================================================
	// opcode spaces
	// ==================================================
	typedef enum logic [3:0] {
		OP8_ORI = 4'd0, OP8_ORR = 4'd1, OP8_ANDI = 4'd2, OP8_ANDR = 4'd3,
		OP8_ADDI = 4'd4, OP8_ADDR = 4'd5, OP8_SUBI = 4'd6, OP8_SUBR = 4'd7,
		OP8_LDI = 4'd8, OP8_BF = 4'd13,
		OP8_PREFIX_I3 = 4'd15 // escape into the i3 space
	} op_i8_e;

	typedef enum logic [3:0] {
		OP3_SHLZI = 4'd0, OP3_SHLZR = 4'd1, OP3_SHLOI = 4'd2, OP3_SHLOR = 4'd3,
		OP3_SHRZI = 4'd4, OP3_SHRZR = 4'd5, OP3_ASRI = 4'd6, OP3_ASRR = 4'd7,
		OP3_OUT = 4'd11,
		OP3_PREFIX_I0 = 4'd15 // escape into the i0 space
	} op_i3_e;

	typedef enum logic [3:0] {OP0_NOT = 4'd0, OP0_TEST = 4'd2, OP0_NOP = 4'd15} op_i0_e;

	// what the alu does with a (Rn) and b (imm or register)
	typedef enum logic [3:0] {
		ALU_PASS_B, ALU_OR, ALU_AND, ALU_ADD, ALU_SUB,
		ALU_NOT, ALU_SHLZ, ALU_SHLO, ALU_SHRZ, ALU_ASR
	} alu_op_e;

	typedef enum logic [2:0] {CM_NONE, CM_WRITE, CM_TEST, CM_OUT, CM_BRANCH} commit_e;

	typedef enum logic [1:0] {COND_Z = 2'd0, COND_NZ = 2'd1, COND_N = 2'd2, COND_AL = 2'd3} cond_e;

	// cond AL, every prefix set, Rn 0
	localparam logic [RN_MSB:0] INSTR_NOP = 23'h006fff;

endpackage

`default_nettype wire
